// File: Bender.yml
package:
  name: divu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - div_arith_pkg.sv
      - div_ctrl_pkg.sv
      - div_stage.sv
      - div_pipeline.sv
      - valid_delay_line.sv
      - oehb_ctrl.sv
      - divu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - divu_sva.sv
      - tb_divu.sv

// File: div_arith_pkg.sv
`default_nettype none

`include "div_config.svh"

package div_arith_pkg;

  // Unsigned word for operands, quotient and partial remainder
  typedef logic [`DIV_WIDTH-1:0] word_t;

  // State handed from one restoring step to the next
  typedef struct packed {
    word_t rem;
    word_t quo;
    word_t dsr;
  } div_step_t;

  // Operand pair accepted by the join
  typedef struct packed {
    word_t lhs;
    word_t rhs;
  } div_operands_t;

endpackage

`default_nettype wire

// File: div_config.svh
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand and quotient width in bits
`define DIV_WIDTH 32

// Operand register, one rank per quotient bit, quotient register
`define DIV_LATENCY (`DIV_WIDTH + 2)

`endif

// File: div_ctrl_pkg.sv
`default_nettype none

`include "div_config.svh"

package div_ctrl_pkg;

  // Holds DIV_LATENCY + 1 tokens in flight
  typedef logic [$clog2(`DIV_LATENCY + 2)-1:0] token_count_t;

  typedef enum logic {
    OEHB_EMPTY = 1'b0,
    OEHB_FULL  = 1'b1
  } oehb_state_t;

endpackage

`default_nettype wire

// File: div_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_pipeline (
  input  logic                         clk,
  input  logic                         en,
  input  div_arith_pkg::div_operands_t operands,
  output div_arith_pkg::word_t         quotient
);

  // Operand register output
  div_arith_pkg::div_step_t first_step;

  // chain[0] feeds the first stage, chain[i+1] is the output of stage i
  div_arith_pkg::div_step_t chain [`DIV_WIDTH+1];

  div_arith_pkg::word_t quotient_q;

  // Operand rank
  // The dividend sits in quo and is shifted out from the top,
  // quotient bits enter from the bottom
  always_ff @(posedge clk) begin
    if (en) begin
      first_step.rem <= '0;
      first_step.quo <= operands.lhs;
      first_step.dsr <= operands.rhs;
    end
  end

  assign chain[0] = first_step;

  // One stage per quotient bit, MSB first
  generate
    for (genvar i = 0; i < `DIV_WIDTH; i++) begin : g_stage
      div_stage u_stage (
        .clk      (clk),
        .en       (en),
        .step_in  (chain[i]),
        .step_out (chain[i+1])
      );
    end
  endgenerate

  // Quotient rank
  // Holds while the output buffer stalls, staying aligned with result_valid
  always_ff @(posedge clk) begin
    if (en) begin
      quotient_q <= chain[`DIV_WIDTH].quo;
    end
  end

  assign quotient = quotient_q;

endmodule

`default_nettype wire

// File: div_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_stage (
  input  logic                     clk,
  input  logic                     en,
  input  div_arith_pkg::div_step_t step_in,
  output div_arith_pkg::div_step_t step_out
);

  div_arith_pkg::word_t shifted;
  logic [`DIV_WIDTH:0]  diff;
  logic                 q_bit;

  // Next dividend bit into the partial remainder
  // The remainder top bit is always zero here, so nothing is lost
  assign shifted = {step_in.rem[`DIV_WIDTH-2:0], step_in.quo[`DIV_WIDTH-1]};

  // Trial subtract with one extra bit for the borrow
  assign diff = {1'b0, shifted} - {1'b0, step_in.dsr};

  // No borrow means the divisor fits
  assign q_bit = ~diff[`DIV_WIDTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (q_bit) begin
        step_out.rem <= diff[`DIV_WIDTH-1:0];
      end else begin
        // Restore
        step_out.rem <= shifted;
      end
      step_out.quo <= {step_in.quo[`DIV_WIDTH-2:0], q_bit};
      step_out.dsr <= step_in.dsr;
    end
  end

endmodule

`default_nettype wire

// File: divu_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module divu_sva (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       lhs_valid,
  input logic                       lhs_ready,
  input logic                       rhs_valid,
  input logic                       rhs_ready,
  input div_arith_pkg::word_t       result_data,
  input logic                       result_valid,
  input logic                       result_ready,
  input div_ctrl_pkg::token_count_t occupancy
);

  int unsigned error_count = 0;
  logic        seen_accept;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seen_accept <= 1'b0;
    end else if (lhs_valid && lhs_ready) begin
      seen_accept <= 1'b1;
    end
  end

  // Stalled result holds until taken
  result_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=> $stable(result_valid) && $stable(result_data))
    else begin
      error_count++;
      $error("result changed while stalled by the consumer");
    end

  reset_clears_a: assert property (@(posedge clk)
    !rst_n |=> !result_valid && occupancy == '0)
    else begin
      error_count++;
      $error("result_valid or occupancy not cleared by reset");
    end

  // Nothing comes out before the first pair goes in
  idle_after_reset_a: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_accept |-> !result_valid && occupancy == '0)
    else begin
      error_count++;
      $error("result or occupancy seen before any pair was accepted");
    end

  // Each side needs the other's valid and a free output slot
  join_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
    lhs_ready == (rhs_valid && (!result_valid || result_ready)) &&
    rhs_ready == (lhs_valid && (!result_valid || result_ready)))
    else begin
      error_count++;
      $error("operand readies do not follow the join rule");
    end

  occupancy_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    occupancy <= `DIV_LATENCY + 1)
    else begin
      error_count++;
      $error("more pairs in flight than the pipeline can hold");
    end

endmodule

`default_nettype wire

// File: divu_top.sv
`timescale 1ns/1ns
`default_nettype none

module divu_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  div_arith_pkg::word_t       lhs_data,
  input  logic                       lhs_valid,
  output logic                       lhs_ready,
  input  div_arith_pkg::word_t       rhs_data,
  input  logic                       rhs_valid,
  output logic                       rhs_ready,
  output div_arith_pkg::word_t       result_data,
  output logic                       result_valid,
  input  logic                       result_ready,
  output div_ctrl_pkg::token_count_t occupancy
);

  // Pipeline enable, the output buffer's ready
  logic pipe_en;
  logic tail_valid;

  div_arith_pkg::div_operands_t operands;
  div_ctrl_pkg::oehb_state_t    buf_state;

  logic                       accept;
  logic                       deliver;
  div_ctrl_pkg::token_count_t occupancy_q;

  assign operands.lhs = lhs_data;
  assign operands.rhs = rhs_data;

  valid_delay_line u_valid_delay_line (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (pipe_en),
    .lhs_valid  (lhs_valid),
    .rhs_valid  (rhs_valid),
    .lhs_ready  (lhs_ready),
    .rhs_ready  (rhs_ready),
    .tail_valid (tail_valid)
  );

  div_pipeline u_div_pipeline (
    .clk      (clk),
    .en       (pipe_en),
    .operands (operands),
    .quotient (result_data)
  );

  oehb_ctrl u_oehb_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (tail_valid),
    .out_ready (result_ready),
    .in_ready  (pipe_en),
    .out_valid (result_valid),
    .state     (buf_state)
  );

  // Pair taken on the join, result taken by the consumer
  assign accept  = lhs_valid & lhs_ready;
  assign deliver = (buf_state == div_ctrl_pkg::OEHB_FULL) & result_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occupancy_q <= '0;
    end else begin
      case ({accept, deliver})
        2'b10:   occupancy_q <= occupancy_q + 1'b1;
        2'b01:   occupancy_q <= occupancy_q - 1'b1;
        default: occupancy_q <= occupancy_q;
      endcase
    end
  end

  assign occupancy = occupancy_q;

endmodule

`default_nettype wire

// File: oehb_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module oehb_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  logic                     out_ready,
  output logic                     in_ready,
  output logic                     out_valid,
  output div_ctrl_pkg::oehb_state_t state
);

  div_ctrl_pkg::oehb_state_t state_q;

  // Slot can take a new token if empty or draining this cycle
  assign in_ready = (state_q == div_ctrl_pkg::OEHB_EMPTY) | out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= div_ctrl_pkg::OEHB_EMPTY;
    end else if (in_ready) begin
      if (in_valid) begin
        state_q <= div_ctrl_pkg::OEHB_FULL;
      end else begin
        state_q <= div_ctrl_pkg::OEHB_EMPTY;
      end
    end
  end

  assign out_valid = (state_q == div_ctrl_pkg::OEHB_FULL);
  assign state     = state_q;

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
div_arith_pkg.sv
div_ctrl_pkg.sv
div_stage.sv
div_pipeline.sv
valid_delay_line.sv
oehb_ctrl.sv
divu_top.sv
tb_clock_gen.sv
divu_sva.sv
tb_divu.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 4,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  // Release just after an edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_divu.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module tb_divu;

  localparam int unsigned RESET_LIMIT = 100;
  localparam int unsigned STALL_LIMIT = 500;
  localparam int unsigned DRAIN_LIMIT = 4000;

  // One scoreboard entry per accepted pair
  typedef struct packed {
    div_arith_pkg::word_t quo;
    logic                 timed;
    logic [31:0]          accept_cycle;
  } expect_t;

  logic                       clk;
  logic                       rst_n;
  div_arith_pkg::word_t       lhs_data;
  logic                       lhs_valid;
  logic                       lhs_ready;
  div_arith_pkg::word_t       rhs_data;
  logic                       rhs_valid;
  logic                       rhs_ready;
  div_arith_pkg::word_t       result_data;
  logic                       result_valid;
  logic                       result_ready;
  div_ctrl_pkg::token_count_t occupancy;

  expect_t     exp_q[$];
  int unsigned cycle;
  int unsigned accepted;
  int unsigned delivered;
  int unsigned ready_pct;
  logic        timing_phase;

  tb_clock_gen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (10)
  ) u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  divu_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .lhs_data     (lhs_data),
    .lhs_valid    (lhs_valid),
    .lhs_ready    (lhs_ready),
    .rhs_data     (rhs_data),
    .rhs_valid    (rhs_valid),
    .rhs_ready    (rhs_ready),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .occupancy    (occupancy)
  );

  bind divu_top divu_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .lhs_valid    (lhs_valid),
    .lhs_ready    (lhs_ready),
    .rhs_valid    (rhs_valid),
    .rhs_ready    (rhs_ready),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .occupancy    (occupancy)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // Unsigned division where a zero divisor gives all ones
  function automatic div_arith_pkg::word_t expected_quotient(input div_arith_pkg::word_t a,
                                                             input div_arith_pkg::word_t b);
    if (b == '0) begin
      return '1;
    end
    return a / b;
  endfunction

  function automatic div_arith_pkg::word_t pick_dividend();
    if ($urandom_range(9) == 0) begin
      return '1;
    end
    return $urandom;
  endfunction

  function automatic div_arith_pkg::word_t pick_divisor(input int unsigned zero_pct);
    int unsigned roll;
    roll = $urandom_range(99);
    if (roll < zero_pct) begin
      return '0;
    end
    if (roll < zero_pct + 10) begin
      return 'd1;
    end
    // Small divisors give wide quotients
    if (roll < zero_pct + 40) begin
      return $urandom_range(255, 2);
    end
    return $urandom;
  endfunction

  // Sampled at the edge before the DUT registers update
  always @(posedge clk) begin : monitor
    expect_t head;
    expect_t entry;
    if (rst_n) begin
      if (result_valid && result_ready) begin
        delivered++;
        assert (exp_q.size() != 0)
          else report_failure("a result was delivered with no pair in flight");
        head = exp_q.pop_front();
        assert (result_data == head.quo)
          else report_failure($sformatf("FAILED result_data expected %h got %h",
                                        head.quo, result_data));
        if (head.timed) begin
          assert (cycle == head.accept_cycle + `DIV_LATENCY)
            else report_failure($sformatf("FAILED result latency expected %h got %h",
                                          `DIV_LATENCY, cycle - head.accept_cycle));
        end
      end
      if (lhs_valid && lhs_ready) begin
        entry.quo          = expected_quotient(lhs_data, rhs_data);
        entry.timed        = timing_phase;
        entry.accept_cycle = cycle;
        exp_q.push_back(entry);
        accepted++;
      end
    end
    cycle++;
  end

  always @(negedge clk) begin
    assert (dut0.u_sva.error_count == 0)
      else report_failure("a bound assertion on divu_top failed");
  end

  task automatic drive_ready();
    forever begin
      @(posedge clk);
      #1;
      result_ready = ($urandom_range(99) < ready_pct);
    end
  endtask

  task automatic wait_for_reset();
    int unsigned waited;
    waited = 0;
    while (!rst_n) begin
      @(posedge clk);
      waited++;
      assert (waited < RESET_LIMIT) else report_failure("reset was never released");
    end
    #1;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic drive_pairs(input int unsigned count, input int unsigned valid_pct,
                             input int unsigned zero_pct);
    int unsigned sent;
    int unsigned stalled;
    sent     = 0;
    stalled  = 0;
    lhs_data = pick_dividend();
    rhs_data = pick_divisor(zero_pct);
    while (sent < count) begin
      // A raised valid stays up until its transfer
      if (!lhs_valid) begin
        lhs_valid = ($urandom_range(99) < valid_pct);
      end
      if (!rhs_valid) begin
        rhs_valid = ($urandom_range(99) < valid_pct);
      end
      @(posedge clk);
      if (lhs_valid && lhs_ready) begin
        sent++;
        stalled = 0;
        #1;
        lhs_valid = 1'b0;
        rhs_valid = 1'b0;
        lhs_data  = pick_dividend();
        rhs_data  = pick_divisor(zero_pct);
      end else begin
        stalled++;
        assert (stalled < STALL_LIMIT)
          else report_failure("operand transfer timed out, the join never fired");
        #1;
      end
    end
  endtask

  task automatic drain_results();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      assert (waited < DRAIN_LIMIT) else report_failure("results did not drain in time");
    end
    assert (occupancy == '0)
      else report_failure($sformatf("FAILED occupancy expected %h got %h", 0, occupancy));
  endtask

  initial begin
    lhs_data     = '0;
    lhs_valid    = 1'b0;
    rhs_data     = '0;
    rhs_valid    = 1'b0;
    result_ready = 1'b0;
    cycle        = 0;
    accepted     = 0;
    delivered    = 0;
    ready_pct    = 100;
    timing_phase = 1'b0;
    void'($urandom(77));
    fork
      drive_ready();
    join_none

    wait_for_reset();
    idle_cycles(5);

    // Consumer always ready for exact latency and one result per cycle
    timing_phase = 1'b1;
    drive_pairs(1, 100, 0);
    drain_results();
    drive_pairs(40, 100, 0);
    drain_results();
    timing_phase = 1'b0;

    ready_pct = 60;
    drive_pairs(300, 70, 10);
    drain_results();

    // Heavy stall fills the pipeline
    ready_pct = 15;
    drive_pairs(120, 90, 10);
    drain_results();

    ready_pct = 50;
    drive_pairs(16, 80, 100);
    drain_results();
    idle_cycles(3);

    if (delivered != accepted || dut0.u_sva.error_count != 0) begin
      report_failure($sformatf("FAILED delivered expected %h got %h", accepted, delivered));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: valid_delay_line.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module valid_delay_line (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  input  logic lhs_valid,
  input  logic rhs_valid,
  output logic lhs_ready,
  output logic rhs_ready,
  output logic tail_valid
);

  // Output buffer adds the last rank of the latency
  localparam int unsigned DEPTH = `DIV_LATENCY - 1;

  logic             join_valid;
  logic [DEPTH-1:0] valid_sr;

  // Two-input join
  assign join_valid = lhs_valid & rhs_valid;

  // Each side waits for the other, and both stall with the pipeline
  assign lhs_ready = rhs_valid & en;
  assign rhs_ready = lhs_valid & en;

  // Token shift register, one rank per datapath rank
  // Bubbles are kept frozen along with tokens
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else if (en) begin
      valid_sr <= {valid_sr[DEPTH-2:0], join_valid};
    end
  end

  // Marks a real quotient at the pipeline output
  assign tail_valid = valid_sr[DEPTH-1];

endmodule

`default_nettype wire
